//--- rtl/mm_config.svh
// ===============================================
// Matmul sizing: Q8.8 element format, array size
// and matrix dimensions, plus derived depths
// ===============================================
`ifndef MM_CONFIG_SVH
`define MM_CONFIG_SVH

// Element format, signed Q8.8
`define MM_WIDTH     16
`define MM_FRAC      8

// Array is MM_BLOCK x MM_BLOCK
`define MM_BLOCK     2
`define MM_INNER     4
`define MM_I_OUTER   4
`define MM_W_OUTER   4

// Block grid of C
`define MM_ROW_BLKS  (`MM_I_OUTER / `MM_BLOCK)
`define MM_COL_BLKS  (`MM_W_OUTER / `MM_BLOCK)

// Buffer words, one per (block, k)
`define MM_I_DEPTH   (`MM_ROW_BLKS * `MM_INNER)
`define MM_W_DEPTH   (`MM_COL_BLKS * `MM_INNER)
`define MM_MAX_DEPTH ((`MM_I_DEPTH > `MM_W_DEPTH) ? `MM_I_DEPTH : `MM_W_DEPTH)
`define MM_ADDR_W    ((`MM_MAX_DEPTH > 1) ? $clog2(`MM_MAX_DEPTH) : 1)

// Block index width, at least one bit
`define MM_MAX_BLKS  ((`MM_ROW_BLKS > `MM_COL_BLKS) ? `MM_ROW_BLKS : `MM_COL_BLKS)
`define MM_BLK_W     ((`MM_MAX_BLKS > 1) ? $clog2(`MM_MAX_BLKS) : 1)

`endif

//--- rtl/mm_pkg.sv
// ===============================================
// Matmul types: elements, accumulators, buffer
// words, result blocks and controller states
// ===============================================
`include "mm_config.svh"

package mm_pkg;

    // Sizes pulled in from the config header
    localparam int elem_w   = `MM_WIDTH;
    localparam int frac_w   = `MM_FRAC;
    localparam int block_n  = `MM_BLOCK;
    localparam int inner_n  = `MM_INNER;
    localparam int row_blks = `MM_ROW_BLKS;
    localparam int col_blks = `MM_COL_BLKS;
    localparam int addr_w   = `MM_ADDR_W;
    localparam int blk_w    = `MM_BLK_W;

    typedef logic signed [elem_w-1:0]   elem_t;  // Q8.8
    typedef logic signed [2*elem_w-1:0] acc_t;   // Full product width

    // One buffer word: a column slice of A or a row slice of B
    typedef elem_t [block_n-1:0] opnd_row_t;

    // Row-major, element (i,j) at i*block_n + j
    typedef elem_t [block_n*block_n-1:0] res_blk_t;

    typedef enum logic [1:0] {
        IDLE,      // Waiting for start
        READ,      // Issuing k reads
        DRAIN,     // Last block in flight
        WAIT_OUT   // Final read held off by full capture
    } ctrl_state_t;

endpackage

//--- rtl/mm_if.sv
// ===============================================
// Accumulate/result bundle between controller,
// MAC array and result capture
// ===============================================
`timescale 1ns/1ps

interface acc_if;

    logic                     acc_clear;    // k == 0, load product
    logic                     acc_en;       // Operand words valid
    logic                     acc_last;     // k == INNER-1
    logic                     res_valid;    // One-cycle block strobe
    mm_pkg::res_blk_t         res_data;     // Shifted, saturated block
    logic [mm_pkg::blk_w-1:0] res_row_blk;
    logic [mm_pkg::blk_w-1:0] res_col_blk;
    logic                     cap_full;     // Capture holds a block

    modport ctrl (
        output acc_clear, acc_en, acc_last, res_row_blk, res_col_blk,
        input  cap_full
    );

    modport array (
        input  acc_clear, acc_en, acc_last,
        output res_valid, res_data
    );

    // Indices come straight from the controller
    modport capture (
        input  res_valid, res_data, res_row_blk, res_col_blk,
        output cap_full
    );

endinterface

//--- rtl/operand_buffer.sv
// ===============================================
// Operand buffer: simple dual-port inferred RAM,
// registered read with one cycle of latency
// ===============================================
`timescale 1ns/1ps

module operand_buffer #(
    parameter type payload_t = logic,
    parameter int  depth     = 4,
    parameter int  addr_w    = (depth > 1) ? $clog2(depth) : 1
) (
    input  logic              accumulator_done_top,
    input  logic              we,
    input  logic [addr_w-1:0] waddr,
    input  payload_t          wdata,
    input  logic              re,
    input  logic [addr_w-1:0] raddr,
    output payload_t          rdata
);

    payload_t mem [depth];  // Plain array, no reset

    // Write port
    always_ff @(posedge accumulator_done_top) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port, holds last word while re is low
    always_ff @(posedge accumulator_done_top) begin
        if (re) begin
            rdata <= mem[raddr];  // Valid the cycle after re
        end
    end

endmodule

//--- rtl/mac_array.sv
// ===============================================
// MAC array: BLOCK x BLOCK outer-product sums,
// Q8.8 rescale with saturation, result strobe
// ===============================================
`timescale 1ns/1ps

module mac_array (
    input  logic              accumulator_done_top,
    input  logic              rst_n,
    input  mm_pkg::opnd_row_t a_row,
    input  mm_pkg::opnd_row_t b_row,
    acc_if.array              acc
);

    localparam int n = mm_pkg::block_n;

    // Signed 16-bit limits in accumulator width
    localparam mm_pkg::acc_t sat_hi = mm_pkg::acc_t'((1 << (mm_pkg::elem_w - 1)) - 1);
    localparam mm_pkg::acc_t sat_lo = -sat_hi - 1;

    mm_pkg::acc_t acc_q [n][n];  // Running sums
    mm_pkg::acc_t prod  [n][n];  // a[i] * b[j] this cycle

    // Drop fraction bits, clamp to element range
    function automatic mm_pkg::elem_t sat_elem(input mm_pkg::acc_t a);
        mm_pkg::acc_t s;
        s = a >>> mm_pkg::frac_w;  // Arithmetic, keeps sign
        if (s > sat_hi) begin
            s = sat_hi;
        end else if (s < sat_lo) begin
            s = sat_lo;
        end
        return mm_pkg::elem_t'(s);
    endfunction

    always_comb begin
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < n; j++) begin
                // Sign-extend both before multiplying
                prod[i][j] = mm_pkg::acc_t'($signed(a_row[i])) *
                             mm_pkg::acc_t'($signed(b_row[j]));
            end
        end
    end

    // Accumulators are payload, cleared by acc_clear instead of reset
    always_ff @(posedge accumulator_done_top) begin
        if (acc.acc_en) begin
            for (int i = 0; i < n; i++) begin
                for (int j = 0; j < n; j++) begin
                    if (acc.acc_clear) begin
                        acc_q[i][j] <= prod[i][j];  // First k of block
                    end else begin
                        acc_q[i][j] <= acc_q[i][j] + prod[i][j];
                    end
                end
            end
        end
    end

    // Strobe lands with the completed sums
    always_ff @(posedge accumulator_done_top) begin
        if (!rst_n) begin
            acc.res_valid <= 1'b0;
        end else begin
            acc.res_valid <= acc.acc_en && acc.acc_last;
        end
    end

    always_comb begin
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < n; j++) begin
                acc.res_data[i*n + j] = sat_elem(acc_q[i][j]);  // Row-major
            end
        end
    end

endmodule

//--- rtl/matmul_ctrl.sv
// ===============================================
// Matmul controller: walks C blocks row-major,
// issues k reads, tracks outputs for done
// ===============================================
`timescale 1ns/1ps

module matmul_ctrl (
    input  logic                      accumulator_done_top,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      out_fire,
    output logic                      buf_re,
    output logic [mm_pkg::addr_w-1:0] a_raddr,
    output logic [mm_pkg::addr_w-1:0] b_raddr,
    output logic                      busy,
    output logic                      done,
    acc_if.ctrl                       acc
);

    localparam int k_w    = (mm_pkg::inner_n > 1) ? $clog2(mm_pkg::inner_n) : 1;
    localparam int blk_w  = mm_pkg::blk_w;
    localparam int addr_w = mm_pkg::addr_w;
    localparam int n_blks = mm_pkg::row_blks * mm_pkg::col_blks;
    localparam int cnt_w  = $clog2(n_blks + 1);

    localparam logic [k_w-1:0]   k_max   = k_w'(mm_pkg::inner_n - 1);
    localparam logic [blk_w-1:0] row_max = blk_w'(mm_pkg::row_blks - 1);
    localparam logic [blk_w-1:0] col_max = blk_w'(mm_pkg::col_blks - 1);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(n_blks - 1);

    mm_pkg::ctrl_state_t state;
    logic [k_w-1:0]      k;        // Inner index
    logic [blk_w-1:0]    row_blk;  // Block being read
    logic [blk_w-1:0]    col_blk;
    logic [cnt_w-1:0]    out_cnt;  // Blocks accepted downstream
    logic                k_last;
    logic                last_blk;
    logic                stall;
    logic                issue;

    assign k_last   = (k == k_max);
    assign last_blk = (row_blk == row_max) && (col_blk == col_max);
    assign stall    = k_last && acc.cap_full;  // Hold final read off a full capture
    // WAIT_OUT always sits at k_last
    assign issue    = ((state == mm_pkg::READ) || (state == mm_pkg::WAIT_OUT)) && !stall;

    assign buf_re  = issue;
    assign a_raddr = addr_w'(int'(row_blk) * mm_pkg::inner_n + int'(k));
    assign b_raddr = addr_w'(int'(col_blk) * mm_pkg::inner_n + int'(k));
    assign busy    = (state != mm_pkg::IDLE);

    always_ff @(posedge accumulator_done_top) begin
        if (!rst_n) begin
            state           <= mm_pkg::IDLE;
            k               <= '0;
            row_blk         <= '0;
            col_blk         <= '0;
            out_cnt         <= '0;
            done            <= 1'b0;
            acc.res_row_blk <= '0;
            acc.res_col_blk <= '0;
        end else begin
            if (out_fire) begin
                out_cnt <= out_cnt + 1'b1;
            end
            case (state)
                mm_pkg::IDLE: begin
                    if (start) begin  // Only accepted here
                        state   <= mm_pkg::READ;
                        k       <= '0;
                        row_blk <= '0;
                        col_blk <= '0;
                        out_cnt <= '0;
                        done    <= 1'b0;
                    end
                end
                mm_pkg::READ, mm_pkg::WAIT_OUT: begin
                    if (stall) begin
                        state <= mm_pkg::WAIT_OUT;
                    end else if (!k_last) begin
                        k <= k + 1'b1;
                    end else begin
                        // Final read issued, tag block for capture
                        k               <= '0;
                        acc.res_row_blk <= row_blk;
                        acc.res_col_blk <= col_blk;
                        if (last_blk) begin
                            state <= mm_pkg::DRAIN;
                        end else begin
                            state <= mm_pkg::READ;
                            if (col_blk == col_max) begin  // Wrap to next row
                                col_blk <= '0;
                                row_blk <= row_blk + 1'b1;
                            end else begin
                                col_blk <= col_blk + 1'b1;
                            end
                        end
                    end
                end
                mm_pkg::DRAIN: begin
                    if (out_fire && (out_cnt == cnt_max)) begin  // Last block taken
                        state <= mm_pkg::IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= mm_pkg::IDLE;
            endcase
        end
    end

    // Flags trail the read by one cycle to meet the data
    always_ff @(posedge accumulator_done_top) begin
        if (!rst_n) begin
            acc.acc_en    <= 1'b0;
            acc.acc_clear <= 1'b0;
            acc.acc_last  <= 1'b0;
        end else begin
            acc.acc_en    <= issue;
            acc.acc_clear <= issue && (k == '0);
            acc.acc_last  <= issue && k_last;
        end
    end

endmodule

//--- rtl/result_capture.sv
// ===============================================
// Result capture: holds a finished block and its
// indices on a valid/ready output
// ===============================================
`timescale 1ns/1ps

module result_capture (
    input  logic                     accumulator_done_top,
    input  logic                     rst_n,
    acc_if.capture                   acc,
    input  logic                     out_ready,
    output logic                     out_valid,
    output mm_pkg::res_blk_t         out_data,
    output logic [mm_pkg::blk_w-1:0] out_row_blk,
    output logic [mm_pkg::blk_w-1:0] out_col_blk,
    output logic                     out_fire
);

    assign out_fire     = out_valid && out_ready;  // Transfer this edge
    assign acc.cap_full = out_valid;               // Unaccepted block held

    // Controller never strobes into a full register
    always_ff @(posedge accumulator_done_top) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (acc.res_valid) begin
            out_valid <= 1'b1;
        end else if (out_fire) begin
            out_valid <= 1'b0;
        end
    end

    // Payload, stable until accepted
    always_ff @(posedge accumulator_done_top) begin
        if (acc.res_valid) begin
            out_data    <= acc.res_data;
            out_row_blk <= acc.res_row_blk;
            out_col_blk <= acc.res_col_blk;
        end
    end

endmodule

//--- rtl/matmul_top.sv
// ===============================================
// Matmul top: operand buffers, controller, MAC
// array and result capture
// ===============================================
`timescale 1ns/1ps
`include "mm_config.svh"

module matmul_top (
    input  logic                   accumulator_done_top,
    input  logic                   rst_n,
    input  logic                   start,
    // A buffer write port
    input  logic                   in_we,
    input  logic [`MM_ADDR_W-1:0]  in_addr,
    input  mm_pkg::opnd_row_t      in_data,
    // B buffer write port
    input  logic                   wb_we,
    input  logic [`MM_ADDR_W-1:0]  wb_addr,
    input  mm_pkg::opnd_row_t      wb_data,
    // Result output
    input  logic                   out_ready,
    output logic                   out_valid,
    output mm_pkg::res_blk_t       out_data,
    output logic [`MM_BLK_W-1:0]   out_row_blk,
    output logic [`MM_BLK_W-1:0]   out_col_blk,
    output logic                   busy,
    output logic                   done
);

    mm_pkg::opnd_row_t       in_rdata;  // A column slice
    mm_pkg::opnd_row_t       wb_rdata;  // B row slice
    logic                    buf_re;    // Shared by both buffers
    logic [`MM_ADDR_W-1:0]   a_raddr;
    logic [`MM_ADDR_W-1:0]   b_raddr;
    logic                    out_fire;

    acc_if u_acc_if ();

    operand_buffer #(
        .payload_t (mm_pkg::opnd_row_t),
        .depth     (`MM_I_DEPTH),
        .addr_w    (`MM_ADDR_W)
    ) u_in_buf (
        .accumulator_done_top (accumulator_done_top),
        .we                   (in_we),
        .waddr                (in_addr),
        .wdata                (in_data),
        .re                   (buf_re),
        .raddr                (a_raddr),
        .rdata                (in_rdata)
    );

    operand_buffer #(
        .payload_t (mm_pkg::opnd_row_t),
        .depth     (`MM_W_DEPTH),
        .addr_w    (`MM_ADDR_W)
    ) u_wb_buf (
        .accumulator_done_top (accumulator_done_top),
        .we                   (wb_we),
        .waddr                (wb_addr),
        .wdata                (wb_data),
        .re                   (buf_re),
        .raddr                (b_raddr),
        .rdata                (wb_rdata)
    );

    matmul_ctrl u_ctrl (
        .accumulator_done_top (accumulator_done_top),
        .rst_n                (rst_n),
        .start                (start),
        .out_fire             (out_fire),
        .buf_re               (buf_re),
        .a_raddr              (a_raddr),
        .b_raddr              (b_raddr),
        .busy                 (busy),
        .done                 (done),
        .acc                  (u_acc_if.ctrl)
    );

    mac_array u_mac_array (
        .accumulator_done_top (accumulator_done_top),
        .rst_n                (rst_n),
        .a_row                (in_rdata),
        .b_row                (wb_rdata),
        .acc                  (u_acc_if.array)
    );

    result_capture u_capture (
        .accumulator_done_top (accumulator_done_top),
        .rst_n                (rst_n),
        .acc                  (u_acc_if.capture),
        .out_ready            (out_ready),
        .out_valid            (out_valid),
        .out_data             (out_data),
        .out_row_blk          (out_row_blk),
        .out_col_blk          (out_col_blk),
        .out_fire             (out_fire)
    );

endmodule

//--- dv/matmul_sva.sv
// ===============================================
// Matmul assertions: reset state, output hold
// under back-pressure, start and done rules
// ===============================================
`timescale 1ns/1ps

module matmul_sva (
    input logic                     accumulator_done_top,
    input logic                     rst_n,
    input logic                     start,
    input logic                     out_ready,
    input logic                     out_valid,
    input mm_pkg::res_blk_t         out_data,
    input logic [mm_pkg::blk_w-1:0] out_row_blk,
    input logic [mm_pkg::blk_w-1:0] out_col_blk,
    input logic                     busy,
    input logic                     done
);

    // Sync reset clears the visible status
    a_reset_state: assert property (@(posedge accumulator_done_top)
        !rst_n |=> !out_valid && !busy && !done)
        else $error("Outputs not low after reset");

    // Stalled block stays put until taken
    a_out_hold: assert property (@(posedge accumulator_done_top) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) &&
            $stable(out_row_blk) && $stable(out_col_blk))
        else $error("Output changed while stalled");

    a_start_taken: assert property (@(posedge accumulator_done_top) disable iff (!rst_n)
        start && !busy |=> busy && !done)  // Accepted start clears done
        else $error("Start in idle not accepted");

    a_done_idle: assert property (@(posedge accumulator_done_top) disable iff (!rst_n)
        done |-> !busy)
        else $error("Done while busy");

endmodule

bind matmul_top matmul_sva u_matmul_sva (
    .accumulator_done_top (accumulator_done_top),
    .rst_n                (rst_n),
    .start                (start),
    .out_ready            (out_ready),
    .out_valid            (out_valid),
    .out_data             (out_data),
    .out_row_blk          (out_row_blk),
    .out_col_blk          (out_col_blk),
    .busy                 (busy),
    .done                 (done)
);

//--- dv/matmul_tb.sv
// ===============================================
// Matmul testbench: table of cases, Q8.8 model,
// stall patterns and start-while-busy pokes
// ===============================================
`timescale 1ns/1ps
`include "mm_config.svh"

module matmul_tb;

    localparam int n          = `MM_BLOCK;
    localparam int inner      = `MM_INNER;
    localparam int rows       = `MM_I_OUTER;
    localparam int cols       = `MM_W_OUTER;
    localparam int n_blks     = `MM_ROW_BLKS * `MM_COL_BLKS;
    localparam int n_cases    = 5;
    localparam int max_cycles = n_cases * n_blks * (inner + 8) * 4;

    logic                   accumulator_done_top = 1'b0;
    logic                   rst_n;
    logic                   start;
    logic                   in_we;
    logic [`MM_ADDR_W-1:0]  in_addr;
    mm_pkg::opnd_row_t      in_data;
    logic                   wb_we;
    logic [`MM_ADDR_W-1:0]  wb_addr;
    mm_pkg::opnd_row_t      wb_data;
    logic                   out_ready;
    logic                   out_valid;
    mm_pkg::res_blk_t       out_data;
    logic [`MM_BLK_W-1:0]   out_row_blk;
    logic [`MM_BLK_W-1:0]   out_col_blk;
    logic                   busy;
    logic                   done;

    mm_pkg::elem_t a_m   [rows][inner];
    mm_pkg::elem_t b_m   [inner][cols];
    mm_pkg::elem_t c_exp [rows][cols];   // Model output
    logic [15:0]   case_tbl [n_cases];   // One nibble each for A kind, B kind, stall and poke
    logic [31:0]   lcg_state = 32'h9d30_4e03;
    int            cycle_cnt = 0;

    matmul_top u_matmul_top (.*);

    always #10 accumulator_done_top = ~accumulator_done_top;  // 20 ns period

    always @(posedge accumulator_done_top) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Regression failed");
            $fatal(1, "Simulation timed out");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Range of about +-8.0 keeps 32-bit sums exact
    function automatic mm_pkg::elem_t rand_elem(input logic [31:0] s);
        return {{4{s[27]}}, s[27:16]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
            $display("Regression failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Kind 0 random, 1 identity, 2 big positive, 3 big with column sign flip
    task automatic fill_matrices(input logic [3:0] a_kind, input logic [3:0] b_kind);
        for (int r = 0; r < rows; r++) begin
            for (int k = 0; k < inner; k++) begin
                lcg_state = lcg_next(lcg_state);
                a_m[r][k] = (a_kind == 4'd2) ? 16'sh4000 : rand_elem(lcg_state);
            end
        end
        for (int k = 0; k < inner; k++) begin
            for (int c = 0; c < cols; c++) begin
                lcg_state = lcg_next(lcg_state);
                case (b_kind)
                    4'd1:    b_m[k][c] = (k == c) ? 16'sh0100 : 16'sh0000;  // 1.0 on diagonal
                    4'd3:    b_m[k][c] = c[0] ? 16'shC000 : 16'sh4000;     // +-64.0
                    default: b_m[k][c] = rand_elem(lcg_state);
                endcase
            end
        end
    endtask

    // Exact sum then arithmetic shift and clamp to 16 bits
    task automatic build_expected();
        longint s;
        for (int i = 0; i < rows; i++) begin
            for (int j = 0; j < cols; j++) begin
                s = 0;
                for (int k = 0; k < inner; k++) begin
                    s += longint'(a_m[i][k]) * longint'(b_m[k][j]);
                end
                s = s >>> `MM_FRAC;
                if (s > 32767) s = 32767;
                if (s < -32768) s = -32768;
                c_exp[i][j] = mm_pkg::elem_t'(s);
            end
        end
    endtask

    task automatic load_buffers();
        mm_pkg::opnd_row_t w;
        for (int addr = 0; addr < `MM_I_DEPTH; addr++) begin
            @(negedge accumulator_done_top);
            for (int i = 0; i < n; i++) begin
                w[i] = a_m[(addr / inner) * n + i][addr % inner];  // Column k of row block
            end
            in_we   = 1'b1;
            in_addr = addr;
            in_data = w;
        end
        @(negedge accumulator_done_top);
        in_we = 1'b0;
        for (int addr = 0; addr < `MM_W_DEPTH; addr++) begin
            for (int j = 0; j < n; j++) begin
                w[j] = b_m[addr % inner][(addr / inner) * n + j];  // Row k of col block
            end
            wb_we   = 1'b1;
            wb_addr = addr;
            wb_data = w;
            @(negedge accumulator_done_top);
        end
        wb_we = 1'b0;
    endtask

    task automatic check_block(input int idx);
        int er;
        int ec;
        er = idx / `MM_COL_BLKS;  // Row-major order
        ec = idx % `MM_COL_BLKS;
        check_val("out_row_blk", er, out_row_blk);
        check_val("out_col_blk", ec, out_col_blk);
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < n; j++) begin
                check_val($sformatf("out_data[%0d]", i * n + j),
                          $unsigned(c_exp[er * n + i][ec * n + j]),
                          $unsigned(out_data[i * n + j]));
            end
        end
    endtask

    task automatic run_case(input logic [15:0] cfg);
        int   got;
        bit   poked;
        logic ready;
        got   = 0;
        poked = 1'b0;
        fill_matrices(cfg[15:12], cfg[11:8]);
        build_expected();
        load_buffers();
        @(negedge accumulator_done_top);
        start = 1'b1;
        @(negedge accumulator_done_top);
        start = 1'b0;
        check_val("busy", 1, busy);
        check_val("done", 0, done);
        while (got < n_blks) begin
            @(negedge accumulator_done_top);
            lcg_state = lcg_next(lcg_state);
            ready     = cfg[4] ? (lcg_state[31:30] == 2'b00) : 1'b1;  // Mostly stalled
            out_ready = ready;
            start     = cfg[0] && (got == 1) && !poked;  // Start while busy
            if (start) poked = 1'b1;
            if (out_valid && ready) begin  // Transfer on the next edge
                check_block(got);
                got++;
            end
        end
        @(negedge accumulator_done_top);
        out_ready = 1'b0;
        start     = 1'b0;
        check_val("done", 1, done);
        repeat (inner + 4) begin  // No extra blocks
            @(negedge accumulator_done_top);
            check_val("out_valid", 0, out_valid);
            check_val("busy", 0, busy);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        in_we     = 1'b0;
        in_addr   = '0;
        in_data   = '0;
        wb_we     = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        out_ready = 1'b0;
        case_tbl[0] = 16'h0100;  // Identity weights
        case_tbl[1] = 16'h0000;  // Random with ready held high
        case_tbl[2] = 16'h2300;  // Saturation both ways
        case_tbl[3] = 16'h0010;  // Random stalls
        case_tbl[4] = 16'h0011;  // Stalls plus ignored start
        repeat (2) @(negedge accumulator_done_top);
        rst_n = 1'b1;
        repeat (5) begin  // Idle after reset
            @(negedge accumulator_done_top);
            check_val("out_valid", 0, out_valid);
            check_val("busy", 0, busy);
            check_val("done", 0, done);
        end
        for (int c = 0; c < n_cases; c++) begin
            run_case(case_tbl[c]);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/mm_pkg.sv
rtl/mm_if.sv
rtl/operand_buffer.sv
rtl/mac_array.sv
rtl/matmul_ctrl.sv
rtl/result_capture.sv
rtl/matmul_top.sv
dv/matmul_sva.sv
dv/matmul_tb.sv

//--- Bender.yml
package:
  name: matmul

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mm_pkg.sv
      - rtl/mm_if.sv
      - rtl/operand_buffer.sv
      - rtl/mac_array.sv
      - rtl/matmul_ctrl.sv
      - rtl/result_capture.sv
      - rtl/matmul_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/matmul_sva.sv
      - dv/matmul_tb.sv
